// ==== hdl/axi_adapter_pkg.sv ====
// Shared bus widths, AXI channel structs and request types of the cache AXI adapter
package axi_adapter_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int unsigned AddrWidth  = 64;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned IdWidth    = 4;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  // byte select bits inside one beat
  localparam int unsigned ByteOffset = 3;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;

  // single word or whole cache line
  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_type_e;

  // AXI burst encodings, wrap is never issued
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } burst_e;

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  // shared by AW and AR
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    burst_e     burst;
    id_t        id;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

  // master to slave
  typedef struct packed {
    ax_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ax_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // slave to master
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
    logic    ar_ready;
  } axi_rsp_t;

endpackage

// ==== hdl/beat_counter.sv ====
// Beat counter that tracks the accepted data beats of one cache-line burst
module beat_counter #(
  parameter int unsigned BeatsPerLine = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            advance_i,
  output logic [$clog2(BeatsPerLine)-1:0] beat_idx_o,
  output logic                            last_beat_o
);

  localparam int unsigned IdxWidth = $clog2(BeatsPerLine);

  logic [IdxWidth-1:0] cnt_q;

  // clear wins over advance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (advance_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign beat_idx_o  = cnt_q;
  assign last_beat_o = (cnt_q == IdxWidth'(BeatsPerLine - 1));

  // the final beat of a line closes the burst, it never moves the count on
  a_no_advance_past_last : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    advance_i |-> !last_beat_o
  ) else $error("beat counter advanced beyond the last beat of a line");

endmodule

// ==== hdl/axi_channel_driver.sv ====
// AXI channel driver that builds the AW, AR and W payloads from the cache request
module axi_channel_driver #(
  parameter int unsigned BeatsPerLine = 4
) (
  input  axi_adapter_pkg::req_type_e                   req_type_i,
  input  axi_adapter_pkg::addr_t                       addr_i,
  input  logic [1:0]                                   size_i,
  input  axi_adapter_pkg::id_t                         id_i,
  input  axi_adapter_pkg::data_t [BeatsPerLine-1:0]    wdata_i,
  input  axi_adapter_pkg::strb_t [BeatsPerLine-1:0]    be_i,
  input  logic [$clog2(BeatsPerLine)-1:0]              beat_idx_i,
  input  logic                                         last_beat_i,
  output axi_adapter_pkg::ax_chan_t                    aw_o,
  output axi_adapter_pkg::ax_chan_t                    ar_o,
  output axi_adapter_pkg::w_chan_t                     w_o
);

  // address bits below the line base
  localparam int unsigned LineOffsetBits = $clog2(BeatsPerLine) + axi_adapter_pkg::ByteOffset;

  logic                   line_req;
  logic [7:0]             burst_len;
  axi_adapter_pkg::addr_t line_base;

  assign line_req  = (req_type_i == axi_adapter_pkg::LINE_REQ);
  assign burst_len = line_req ? 8'(BeatsPerLine - 1) : 8'd0;

  always_comb begin
    line_base = addr_i;
    line_base[LineOffsetBits-1:0] = '0;
  end

  // --------------------------------------------------
  // address channels
  // --------------------------------------------------
  always_comb begin
    aw_o.addr  = addr_i;
    aw_o.len   = burst_len;
    aw_o.size  = {1'b0, size_i};
    aw_o.burst = axi_adapter_pkg::BURST_INCR;
    aw_o.id    = id_i;

    // incrementing line reads start at the line base
    ar_o.addr  = line_req ? line_base : addr_i;
    ar_o.len   = burst_len;
    ar_o.size  = {1'b0, size_i};
    ar_o.burst = axi_adapter_pkg::BURST_INCR;
    ar_o.id    = id_i;
  end

  // write data follows the beat index for lines, word zero otherwise
  assign w_o.data = line_req ? wdata_i[beat_idx_i] : wdata_i[0];
  assign w_o.strb = line_req ? be_i[beat_idx_i] : be_i[0];
  assign w_o.last = line_req ? last_beat_i : 1'b1;

endmodule

// ==== hdl/line_assembler.sv ====
// Line assembler that collects read beats into the line buffer and flags the critical word
module line_assembler #(
  parameter int unsigned BeatsPerLine = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      start_i,
  input  axi_adapter_pkg::addr_t                    addr_i,
  input  logic                                      line_req_i,
  input  logic                                      capture_i,
  input  logic [$clog2(BeatsPerLine)-1:0]           beat_idx_i,
  input  axi_adapter_pkg::r_chan_t                  r_i,
  output axi_adapter_pkg::data_t [BeatsPerLine-1:0] line_o,
  output axi_adapter_pkg::id_t                      id_o,
  output axi_adapter_pkg::data_t                    critical_word_o,
  output logic                                      critical_word_valid_o
);

  localparam int unsigned IdxWidth = $clog2(BeatsPerLine);

  logic [IdxWidth-1:0]                       offset_q;
  logic                                      line_req_q;
  logic [IdxWidth-1:0]                       slot;
  axi_adapter_pkg::data_t [BeatsPerLine-1:0] line_q;
  axi_adapter_pkg::id_t                      id_q;

  // --------------------------------------------------
  // request context, taken when AR is accepted
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      line_req_q <= 1'b0;
      id_q       <= '0;
    end else begin
      if (start_i) begin
        offset_q   <= addr_i[axi_adapter_pkg::ByteOffset +: IdxWidth];
        line_req_q <= line_req_i;
      end
      if (capture_i && r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

  // single reads always land in slot zero
  assign slot = line_req_q ? beat_idx_i : '0;

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      line_q[slot] <= r_i.data;
    end
  end

  assign line_o = line_q;
  assign id_o   = id_q;

  // critical word goes out straight from the bus, one cycle ahead of the buffer
  assign critical_word_o       = r_i.data;
  assign critical_word_valid_o = capture_i && (!line_req_q || (beat_idx_i == offset_q));

endmodule

// ==== hdl/axi_adapter_fsm.sv ====
// Transaction FSM of the adapter that sequences the AXI channels for one request at a time
module axi_adapter_fsm #(
  parameter int unsigned BeatsPerLine = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  axi_adapter_pkg::req_type_e req_type_i,
  input  axi_adapter_pkg::axi_rsp_t  axi_rsp_i,
  input  logic                       last_beat_i,
  output logic                       gnt_o,
  output logic                       busy_o,
  output logic                       valid_o,
  output logic                       aw_valid_o,
  output logic                       w_valid_o,
  output logic                       ar_valid_o,
  output logic                       b_ready_o,
  output logic                       r_ready_o,
  output logic                       cnt_clear_o,
  output logic                       cnt_advance_o,
  output logic                       rd_start_o,
  output logic                       rd_capture_o,
  output logic                       wr_id_sel_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW_W,
    WAIT_AW,
    WAIT_W,
    WAIT_B,
    WAIT_R,
    COMPLETE_READ
  } state_e;

  state_e state_q;
  state_e state_d;

  logic w_hs;
  logic r_hs;
  logic ar_hs;
  logic w_last;

  // line length is limited to what the beat index and len field are sized for
  if (!(BeatsPerLine inside {2, 4, 8})) begin : g_beats_check
    $error("BeatsPerLine must be 2, 4 or 8");
  end

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------
  assign w_hs   = w_valid_o && axi_rsp_i.w_ready;
  assign r_hs   = r_ready_o && axi_rsp_i.r_valid;
  assign ar_hs  = ar_valid_o && axi_rsp_i.ar_ready;
  // single writes have only one beat
  assign w_last = (req_type_i == axi_adapter_pkg::SINGLE_REQ) || last_beat_i;

  // --------------------------------------------------
  // next state and channel control
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    gnt_o      = 1'b0;
    valid_o    = 1'b0;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    ar_valid_o = 1'b0;
    b_ready_o  = 1'b0;
    r_ready_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          if (we_i) begin
            state_d = WAIT_AW_W;
          end else begin
            // reads go out at once and are granted on AR acceptance
            ar_valid_o = 1'b1;
            if (axi_rsp_i.ar_ready) begin
              gnt_o   = 1'b1;
              state_d = WAIT_R;
            end
          end
        end
      end

      // address and data both still owed
      WAIT_AW_W: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        case ({axi_rsp_i.aw_ready, axi_rsp_i.w_ready && w_last})
          2'b11: begin
            gnt_o   = 1'b1;
            state_d = WAIT_B;
          end
          2'b10:   state_d = WAIT_W;
          2'b01:   state_d = WAIT_AW;
          default: state_d = WAIT_AW_W;
        endcase
      end

      // all data sent, address pending
      WAIT_AW: begin
        aw_valid_o = 1'b1;
        if (axi_rsp_i.aw_ready) begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
      end

      // address taken, remaining beats pending
      WAIT_W: begin
        w_valid_o = 1'b1;
        if (axi_rsp_i.w_ready && w_last) begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
      end

      WAIT_B: begin
        if (axi_rsp_i.b_valid) begin
          b_ready_o = 1'b1;
          valid_o   = 1'b1;
          state_d   = IDLE;
        end
      end

      WAIT_R: begin
        r_ready_o = 1'b1;
        if (axi_rsp_i.r_valid && axi_rsp_i.r.last) begin
          state_d = COMPLETE_READ;
        end
      end

      // line buffer holds the last beat now
      COMPLETE_READ: begin
        valid_o = 1'b1;
        state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign busy_o = (state_q != IDLE);

  // counter sits at zero between requests and stops on the closing beat
  assign cnt_clear_o   = (state_q == IDLE);
  assign cnt_advance_o = (w_hs && !w_last) || (r_hs && !axi_rsp_i.r.last);

  assign rd_start_o   = ar_hs;
  assign rd_capture_o = r_hs;
  assign wr_id_sel_o  = (state_q == WAIT_B);

  a_gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    gnt_o |-> req_i
  ) else $error("grant issued without a pending request");

endmodule

// ==== hdl/axi_adapter.sv ====
// Cache to AXI adapter top level that joins the FSM, beat counter, channel driver and line buffer
module axi_adapter #(
  parameter int unsigned BeatsPerLine = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // cache side
  input  logic                                      req_i,
  input  axi_adapter_pkg::req_type_e                req_type_i,
  output logic                                      gnt_o,
  output logic                                      busy_o,
  input  axi_adapter_pkg::addr_t                    addr_i,
  input  logic                                      we_i,
  input  axi_adapter_pkg::data_t [BeatsPerLine-1:0] wdata_i,
  input  axi_adapter_pkg::strb_t [BeatsPerLine-1:0] be_i,
  input  logic [1:0]                                size_i,
  input  axi_adapter_pkg::id_t                      id_i,
  output logic                                      valid_o,
  output axi_adapter_pkg::data_t [BeatsPerLine-1:0] rdata_o,
  output axi_adapter_pkg::id_t                      id_o,
  output axi_adapter_pkg::data_t                    critical_word_o,
  output logic                                      critical_word_valid_o,
  // bus side
  output axi_adapter_pkg::axi_req_t                 axi_req_o,
  input  axi_adapter_pkg::axi_rsp_t                 axi_rsp_i
);

  logic                              cnt_clear;
  logic                              cnt_advance;
  logic [$clog2(BeatsPerLine)-1:0]   beat_idx;
  logic                              last_beat;
  logic                              rd_start;
  logic                              rd_capture;
  logic                              wr_id_sel;
  logic                              aw_valid;
  logic                              w_valid;
  logic                              ar_valid;
  logic                              b_ready;
  logic                              r_ready;
  axi_adapter_pkg::ax_chan_t         aw;
  axi_adapter_pkg::ax_chan_t         ar;
  axi_adapter_pkg::w_chan_t          w;
  axi_adapter_pkg::id_t              rd_id;

  axi_adapter_fsm #(
    .BeatsPerLine (BeatsPerLine)
  ) u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .req_type_i    (req_type_i),
    .axi_rsp_i     (axi_rsp_i),
    .last_beat_i   (last_beat),
    .gnt_o         (gnt_o),
    .busy_o        (busy_o),
    .valid_o       (valid_o),
    .aw_valid_o    (aw_valid),
    .w_valid_o     (w_valid),
    .ar_valid_o    (ar_valid),
    .b_ready_o     (b_ready),
    .r_ready_o     (r_ready),
    .cnt_clear_o   (cnt_clear),
    .cnt_advance_o (cnt_advance),
    .rd_start_o    (rd_start),
    .rd_capture_o  (rd_capture),
    .wr_id_sel_o   (wr_id_sel)
  );

  beat_counter #(
    .BeatsPerLine (BeatsPerLine)
  ) u_beat_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (cnt_clear),
    .advance_i   (cnt_advance),
    .beat_idx_o  (beat_idx),
    .last_beat_o (last_beat)
  );

  axi_channel_driver #(
    .BeatsPerLine (BeatsPerLine)
  ) u_channel_driver (
    .req_type_i  (req_type_i),
    .addr_i      (addr_i),
    .size_i      (size_i),
    .id_i        (id_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .beat_idx_i  (beat_idx),
    .last_beat_i (last_beat),
    .aw_o        (aw),
    .ar_o        (ar),
    .w_o         (w)
  );

  // line-ness is latched inside the assembler when AR is accepted
  line_assembler #(
    .BeatsPerLine (BeatsPerLine)
  ) u_line_assembler (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .start_i               (rd_start),
    .addr_i                (addr_i),
    .line_req_i            (req_type_i == axi_adapter_pkg::LINE_REQ),
    .capture_i             (rd_capture),
    .beat_idx_i            (beat_idx),
    .r_i                   (axi_rsp_i.r),
    .line_o                (rdata_o),
    .id_o                  (rd_id),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

  // --------------------------------------------------
  // bus request assembly
  // --------------------------------------------------
  always_comb begin
    axi_req_o.aw       = aw;
    axi_req_o.aw_valid = aw_valid;
    axi_req_o.w        = w;
    axi_req_o.w_valid  = w_valid;
    axi_req_o.b_ready  = b_ready;
    axi_req_o.ar       = ar;
    axi_req_o.ar_valid = ar_valid;
    axi_req_o.r_ready  = r_ready;
  end

  // write responses carry their own ID
  assign id_o = wr_id_sel ? axi_rsp_i.b.id : rd_id;

  // a stalled W beat must hold its payload until the slave takes it
  a_w_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (axi_req_o.w_valid && !axi_rsp_i.w_ready) |=> (axi_req_o.w_valid && $stable(axi_req_o.w))
  ) else $error("W beat dropped or changed while stalled");

endmodule

// ==== dv/axi_mem_model.sv ====
// AXI memory slave for the testbench with per-channel ready and valid delays over a sparse memory
module axi_mem_model (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // delay in cycles per channel, index 0 aw, 1 w, 2 b, 3 ar, 4 r
  input  logic [4:0][1:0]           delay_i,
  input  axi_adapter_pkg::axi_req_t axi_req_i,
  output axi_adapter_pkg::axi_rsp_t axi_rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  axi_adapter_pkg::data_t    mem [logic [60:0]];
  axi_adapter_pkg::axi_rsp_t rsp_q;
  axi_adapter_pkg::ax_chan_t aw_q;
  axi_adapter_pkg::ax_chan_t ar_q;
  axi_adapter_pkg::data_t    w_data [$];
  axi_adapter_pkg::strb_t    w_strb [$];
  logic                      aw_have;
  logic                      w_done;
  logic                      r_active;
  logic [7:0]                r_beat;
  int                        aw_wait;
  int                        w_wait;
  int                        b_wait;
  int                        ar_wait;
  int                        r_wait;

  assign axi_rsp_o = rsp_q;

  // unwritten words read back a pattern of their full address
  function automatic axi_adapter_pkg::data_t read_word(input logic [60:0] waddr);
    if (mem.exists(waddr)) begin
      return mem[waddr];
    end
    return ({waddr, 3'b000} * 64'h9E37_79B9_7F4A_7C15) ^ 64'h0123_4567_89AB_CDEF;
  endfunction

  task automatic write_word(input logic [60:0] waddr, input axi_adapter_pkg::data_t data,
                            input axi_adapter_pkg::strb_t strb);
    axi_adapter_pkg::data_t word;
    word = read_word(waddr);
    for (int b = 0; b < axi_adapter_pkg::StrbWidth; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    mem[waddr] = word;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q    <= '0;
      aw_q     <= '0;
      ar_q     <= '0;
      aw_have  <= 1'b0;
      w_done   <= 1'b0;
      r_active <= 1'b0;
      r_beat   <= '0;
      aw_wait  <= 0;
      w_wait   <= 0;
      b_wait   <= 0;
      ar_wait  <= 0;
      r_wait   <= 0;
      w_data.delete();
      w_strb.delete();
    end else begin
      // --------------------------------------------------
      // write address and data
      // --------------------------------------------------
      if (rsp_q.aw_ready && axi_req_i.aw_valid) begin
        rsp_q.aw_ready <= 1'b0;
        aw_q           <= axi_req_i.aw;
        aw_have        <= 1'b1;
        aw_wait        <= 0;
      end else if (axi_req_i.aw_valid && !aw_have) begin
        if (aw_wait >= delay_i[0]) rsp_q.aw_ready <= 1'b1;
        else aw_wait <= aw_wait + 1;
      end

      if (rsp_q.w_ready && axi_req_i.w_valid) begin
        rsp_q.w_ready <= 1'b0;
        w_wait        <= 0;
        w_data.push_back(axi_req_i.w.data);
        w_strb.push_back(axi_req_i.w.strb);
        if (axi_req_i.w.last) w_done <= 1'b1;
      end else if (axi_req_i.w_valid && !w_done) begin
        if (w_wait >= delay_i[1]) rsp_q.w_ready <= 1'b1;
        else w_wait <= w_wait + 1;
      end

      // memory is updated when the response goes out
      if (rsp_q.b_valid) begin
        if (axi_req_i.b_ready) rsp_q.b_valid <= 1'b0;
      end else if (aw_have && w_done) begin
        if (b_wait >= delay_i[2]) begin
          for (int i = 0; i < w_data.size(); i++) begin
            write_word(aw_q.addr[63:3] + 61'(i), w_data[i], w_strb[i]);
          end
          w_data.delete();
          w_strb.delete();
          rsp_q.b_valid <= 1'b1;
          rsp_q.b.id    <= aw_q.id;
          rsp_q.b.resp  <= 2'b00;
          aw_have       <= 1'b0;
          w_done        <= 1'b0;
          b_wait        <= 0;
        end else begin
          b_wait <= b_wait + 1;
        end
      end

      // --------------------------------------------------
      // read address and data
      // --------------------------------------------------
      if (rsp_q.ar_ready && axi_req_i.ar_valid) begin
        rsp_q.ar_ready <= 1'b0;
        ar_q           <= axi_req_i.ar;
        r_active       <= 1'b1;
        r_beat         <= '0;
        ar_wait        <= 0;
      end else if (axi_req_i.ar_valid && !r_active) begin
        if (ar_wait >= delay_i[3]) rsp_q.ar_ready <= 1'b1;
        else ar_wait <= ar_wait + 1;
      end

      if (rsp_q.r_valid) begin
        if (axi_req_i.r_ready) begin
          rsp_q.r_valid <= 1'b0;
          if (rsp_q.r.last) r_active <= 1'b0;
          else r_beat <= r_beat + 1'b1;
        end
      end else if (r_active) begin
        if (r_wait >= delay_i[4]) begin
          rsp_q.r_valid <= 1'b1;
          rsp_q.r.data  <= read_word(ar_q.addr[63:3] + 61'(r_beat));
          rsp_q.r.id    <= ar_q.id;
          rsp_q.r.last  <= (r_beat == ar_q.len);
          r_wait        <= 0;
        end else begin
          r_wait <= r_wait + 1;
        end
      end
    end
  end

endmodule

// ==== dv/tb_axi_adapter.sv ====
// Testbench for the cache AXI adapter with random requests checked against a reference model
module tb_axi_adapter;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned BeatsPerLine = 4;
  localparam int unsigned NumReqs      = 300;
  localparam int unsigned Timeout      = 200;

  logic                                      clk_i;
  logic                                      rst_ni;
  logic                                      req;
  logic                                      we;
  axi_adapter_pkg::req_type_e                req_type;
  axi_adapter_pkg::addr_t                    addr;
  axi_adapter_pkg::data_t [BeatsPerLine-1:0] wdata;
  axi_adapter_pkg::strb_t [BeatsPerLine-1:0] be;
  logic [1:0]                                size;
  axi_adapter_pkg::id_t                      id;
  logic                                      gnt;
  logic                                      busy;
  logic                                      valid;
  axi_adapter_pkg::data_t [BeatsPerLine-1:0] rdata;
  axi_adapter_pkg::id_t                      rid;
  axi_adapter_pkg::data_t                    crit_word;
  logic                                      crit_valid;
  axi_adapter_pkg::axi_req_t                 axi_req;
  axi_adapter_pkg::axi_rsp_t                 axi_rsp;
  logic [4:0][1:0]                           delays;

  // reference memory and run state
  axi_adapter_pkg::data_t ref_mem [logic [60:0]];
  logic [31:0]            seed = 32'd82498;
  int                     check_errors = 0;
  int                     timeouts = 0;
  logic                   timed_out = 1'b0;

  // per-request observations
  int                        aw_cnt;
  int                        ar_cnt;
  int                        gnt_cnt;
  int                        valid_cnt;
  int                        crit_cnt;
  axi_adapter_pkg::ax_chan_t aw_seen;
  axi_adapter_pkg::ax_chan_t ar_seen;
  axi_adapter_pkg::w_chan_t  w_seen [$];
  axi_adapter_pkg::data_t    crit_seen;
  axi_adapter_pkg::data_t    [BeatsPerLine-1:0] rdata_seen;
  axi_adapter_pkg::id_t      id_seen;

  axi_adapter #(
    .BeatsPerLine (BeatsPerLine)
  ) u_axi_adapter (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req),
    .req_type_i            (req_type),
    .gnt_o                 (gnt),
    .busy_o                (busy),
    .addr_i                (addr),
    .we_i                  (we),
    .wdata_i               (wdata),
    .be_i                  (be),
    .size_i                (size),
    .id_i                  (id),
    .valid_o               (valid),
    .rdata_o               (rdata),
    .id_o                  (rid),
    .critical_word_o       (crit_word),
    .critical_word_valid_o (crit_valid),
    .axi_req_o             (axi_req),
    .axi_rsp_i             (axi_rsp)
  );

  axi_mem_model u_axi_mem_model (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .delay_i   (delays),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic axi_adapter_pkg::data_t ref_word(input logic [60:0] waddr);
    if (ref_mem.exists(waddr)) begin
      return ref_mem[waddr];
    end
    return ({waddr, 3'b000} * 64'h9E37_79B9_7F4A_7C15) ^ 64'h0123_4567_89AB_CDEF;
  endfunction

  task automatic ref_write(input logic [60:0] waddr, input axi_adapter_pkg::data_t data,
                           input axi_adapter_pkg::strb_t strb);
    axi_adapter_pkg::data_t word;
    word = ref_word(waddr);
    for (int b = 0; b < axi_adapter_pkg::StrbWidth; b++) begin
      if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    ref_mem[waddr] = word;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
      check_errors++;
    end
  endtask

  // --------------------------------------------------
  // bus and cache-side sampling, once per clock edge
  // --------------------------------------------------
  task automatic observe_cycle();
    if (axi_req.aw_valid && axi_rsp.aw_ready) begin
      aw_cnt++;
      aw_seen = axi_req.aw;
    end
    if (axi_req.w_valid && axi_rsp.w_ready) w_seen.push_back(axi_req.w);
    if (axi_req.ar_valid && axi_rsp.ar_ready) begin
      ar_cnt++;
      ar_seen = axi_req.ar;
    end
    if (crit_valid) begin
      crit_cnt++;
      crit_seen = crit_word;
    end
    if (gnt) gnt_cnt++;
    if (valid) begin
      valid_cnt++;
      rdata_seen = rdata;
      id_seen    = rid;
    end
  endtask

  task automatic run_request(input int n);
    logic [31:0]  r;
    logic [31:0]  rnd;
    logic [60:0]  word;
    logic [60:0]  base;
    int           beats;
    int           cycles;
    logic         done;
    string        tag;
    r     = next_rand();
    word  = 61'h1000_0000 + 61'(r[23:16]);
    beats = r[25] ? BeatsPerLine : 1;
    if (r[24] && r[25]) word[$clog2(BeatsPerLine)-1:0] = '0;
    base  = word & ~61'(BeatsPerLine - 1);
    tag   = $sformatf("req %0d %s %s", n, r[25] ? "line" : "single", r[24] ? "write" : "read");
    aw_cnt = 0;
    ar_cnt = 0;
    gnt_cnt = 0;
    valid_cnt = 0;
    crit_cnt = 0;
    w_seen.delete();
    req      <= 1'b1;
    we       <= r[24];
    req_type <= r[25] ? axi_adapter_pkg::LINE_REQ : axi_adapter_pkg::SINGLE_REQ;
    addr     <= {word, 3'b000};
    size     <= 2'b11;
    id       <= r[29:26];
    rnd       = next_rand();
    delays   <= rnd[31:22];
    for (int i = 0; i < BeatsPerLine; i++) begin
      wdata[i] <= {next_rand(), next_rand()};
      rnd       = next_rand();
      be[i]    <= rnd[23:16];
    end

    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < Timeout) begin
      @(posedge clk_i);
      observe_cycle();
      done = gnt;
      cycles++;
    end
    if (!done) begin
      $display("timeout waiting for gnt_o in %s", tag);
      timeouts++;
      timed_out = 1'b1;
      return;
    end
    req <= 1'b0;

    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < Timeout) begin
      @(posedge clk_i);
      observe_cycle();
      assert (busy) else begin
        $display("busy_o was low between grant and completion in %s", tag);
        check_errors++;
      end
      done = valid;
      cycles++;
    end
    if (!done) begin
      $display("timeout waiting for valid_o in %s", tag);
      timeouts++;
      timed_out = 1'b1;
      return;
    end

    check_value({tag, " grants"}, 1, gnt_cnt);
    check_value({tag, " completions"}, 1, valid_cnt);
    check_value({tag, " id_o"}, r[29:26], id_seen);
    if (r[24]) begin
      check_value({tag, " aw count"}, 1, aw_cnt);
      check_value({tag, " ar count"}, 0, ar_cnt);
      check_value({tag, " aw addr"}, {word, 3'b000}, aw_seen.addr);
      check_value({tag, " aw len"}, beats - 1, aw_seen.len);
      check_value({tag, " aw burst"}, axi_adapter_pkg::BURST_INCR, aw_seen.burst);
      check_value({tag, " aw id"}, r[29:26], aw_seen.id);
      check_value({tag, " w beats"}, beats, w_seen.size());
      for (int i = 0; i < beats && i < w_seen.size(); i++) begin
        check_value($sformatf("%s w data %0d", tag, i), wdata[i], w_seen[i].data);
        check_value($sformatf("%s w strb %0d", tag, i), be[i], w_seen[i].strb);
        check_value($sformatf("%s w last %0d", tag, i), i == beats - 1, w_seen[i].last);
        ref_write(word + 61'(i), wdata[i], be[i]);
      end
    end else begin
      check_value({tag, " ar count"}, 1, ar_cnt);
      check_value({tag, " aw count"}, 0, aw_cnt);
      check_value({tag, " w beats"}, 0, w_seen.size());
      check_value({tag, " ar addr"}, {(beats > 1) ? base : word, 3'b000}, ar_seen.addr);
      check_value({tag, " ar len"}, beats - 1, ar_seen.len);
      check_value({tag, " ar burst"}, axi_adapter_pkg::BURST_INCR, ar_seen.burst);
      check_value({tag, " critical pulses"}, 1, crit_cnt);
      check_value({tag, " critical word"}, ref_word(word), crit_seen);
      if (beats > 1) begin
        for (int i = 0; i < BeatsPerLine; i++) begin
          check_value($sformatf("%s rdata %0d", tag, i), ref_word(base + 61'(i)),
                      rdata_seen[i]);
        end
      end else begin
        check_value({tag, " rdata 0"}, ref_word(word), rdata_seen[0]);
      end
    end
  endtask

  initial begin
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    req_type = axi_adapter_pkg::SINGLE_REQ;
    addr     = '0;
    wdata    = '0;
    be       = '0;
    size     = 2'b11;
    id       = '0;
    delays   = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // quiet outputs before the first request
    repeat (3) begin
      @(posedge clk_i);
      check_value("idle busy_o", 0, busy);
      check_value("idle gnt_o", 0, gnt);
      check_value("idle valid_o", 0, valid);
      check_value("idle critical_word_valid_o", 0, crit_valid);
      check_value("idle bus valids", 0,
                  {axi_req.aw_valid, axi_req.w_valid, axi_req.ar_valid});
      check_value("idle bus readies", 0, {axi_req.b_ready, axi_req.r_ready});
    end

    for (int n = 0; n < NumReqs; n++) begin
      run_request(n);
      if (timed_out) break;
    end

    $display("errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/axi_adapter_pkg.sv
hdl/beat_counter.sv
hdl/axi_channel_driver.sv
hdl/line_assembler.sv
hdl/axi_adapter_fsm.sv
hdl/axi_adapter.sv
dv/axi_mem_model.sv
dv/tb_axi_adapter.sv

// ==== Bender.yml ====
package:
  name: axi_adapter

sources:
  - hdl/axi_adapter_pkg.sv
  - hdl/beat_counter.sv
  - hdl/axi_channel_driver.sv
  - hdl/line_assembler.sv
  - hdl/axi_adapter_fsm.sv
  - hdl/axi_adapter.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/tb_axi_adapter.sv
